//--- elastic_buffer.sv
// Two-entry valid/ready buffer with a registered output.
// An output register is backed by one skid entry, so ready_in only
// reflects whether the skid entry is free and never follows valid_in.
// Order is first-in first-out. The payload type is a parameter.

`timescale 1ns/1ps
`default_nettype none

module elastic_buffer #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,

    input  wire logic     valid_in,
    output      logic     ready_in,
    input  wire payload_t data_in,

    output      logic     valid_out,
    input  wire logic     ready_out,
    output      payload_t data_out
);

    logic     out_valid;
    payload_t out_data;
    logic     skid_valid;
    payload_t skid_data;

    logic     out_load;
    logic     in_fire;

    // output register may take a new entry when empty or being drained
    assign out_load = !out_valid || ready_out;
    assign in_fire  = valid_in && ready_in;

    // full when both the output register and the skid entry hold data
    assign ready_in  = !skid_valid;
    assign valid_out = out_valid;
    assign data_out  = out_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (out_load) begin
                // the skid entry is older than anything on the input
                if (skid_valid) begin
                    out_valid  <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    out_valid <= valid_in;
                end
            end else if (in_fire) begin
                // output stalled, park the new entry
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (valid_in) begin
                out_data <= data_in;
            end
        end else if (in_fire) begin
            skid_data <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- list.f
rop_pkg.sv
elastic_buffer.sv
rop_csr.sv
rop_agent.sv
tb_rop_agent.sv

//--- rop_agent.sv
// Render-output agent of the GPU core, top level.
// Each execute request is split into a render-output bus request and a
// commit record, each behind its own elastic buffer, so that both are
// taken on the same edge or not at all. Also holds the configuration
// registers behind the CSR port.

`timescale 1ns/1ps
`default_nettype none

module rop_agent (
    input  wire logic                     clk,
    input  wire logic                     rst_n,

    // execute stage
    input  wire logic                     exec_valid,
    output      logic                     exec_ready,
    input  wire rop_pkg::exec_req_t       exec_data,

    // render-output bus
    output      logic                     rop_valid,
    input  wire logic                     rop_ready,
    output      rop_pkg::rop_req_t        rop_data,

    // commit
    output      logic                     commit_valid,
    input  wire logic                     commit_ready,
    output      rop_pkg::commit_t         commit_data,

    // CSR port
    input  wire logic                     csr_valid,
    input  wire rop_pkg::csr_req_t        csr_data,
    output      logic                     csr_rsp_valid,
    output      logic [rop_pkg::xlen-1:0] csr_rsp_data
);

    rop_pkg::rop_req_t req_in;
    rop_pkg::commit_t  rsp_in;

    logic req_valid_in;
    logic req_ready_in;
    logic rsp_valid_in;
    logic rsp_ready_in;

    // unpack the fragment of each lane from the source operands
    always_comb begin
        req_in      = '0;
        req_in.uuid = exec_data.uuid;
        req_in.mask = exec_data.tmask;
        for (int i = 0; i < rop_pkg::num_lanes; i++) begin
            req_in.face[i]  = exec_data.rs1[i][rop_pkg::face_bit];
            req_in.pos_x[i] = exec_data.rs1[i][rop_pkg::pos_x_lsb +: rop_pkg::dim_bits];
            req_in.pos_y[i] = exec_data.rs1[i][rop_pkg::pos_y_lsb +: rop_pkg::dim_bits];
            req_in.color[i] = exec_data.rs2[i][31:0];
            req_in.depth[i] = exec_data.rs3[i][rop_pkg::depth_bits-1:0];
        end
    end

    // the commit only retires the instruction, nothing is written back
    always_comb begin
        rsp_in       = '0;
        rsp_in.uuid  = exec_data.uuid;
        rsp_in.wid   = exec_data.wid;
        rsp_in.tmask = exec_data.tmask;
        rsp_in.pc    = exec_data.pc;
        rsp_in.pid   = exec_data.pid;
        rsp_in.sop   = exec_data.sop;
        rsp_in.eop   = exec_data.eop;
    end

    // fork: each side only pushes when the other can take it too
    assign req_valid_in = exec_valid && rsp_ready_in;
    assign rsp_valid_in = exec_valid && req_ready_in;
    assign exec_ready   = req_ready_in && rsp_ready_in;

    rop_csr csr0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_valid     (csr_valid),
        .csr_data      (csr_data),
        .csr_rsp_valid (csr_rsp_valid),
        .csr_rsp_data  (csr_rsp_data),
        .rop_csrs      ()
    );

    elastic_buffer #(
        .payload_t (rop_pkg::rop_req_t)
    ) req_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (req_valid_in),
        .ready_in  (req_ready_in),
        .data_in   (req_in),
        .valid_out (rop_valid),
        .ready_out (rop_ready),
        .data_out  (rop_data)
    );

    elastic_buffer #(
        .payload_t (rop_pkg::commit_t)
    ) rsp_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (rsp_valid_in),
        .ready_in  (rsp_ready_in),
        .data_in   (rsp_in),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (commit_data)
    );

endmodule

`default_nettype wire

//--- rop_csr.sv
// Render-output configuration registers.
// A write lands on the edge where it is presented. A read returns the
// register value on csr_rsp_data for one cycle after that edge, and an
// unknown address reads zero. The full set is also offered as a struct.

`timescale 1ns/1ps
`default_nettype none

module rop_csr (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire logic                    csr_valid,
    input  wire rop_pkg::csr_req_t       csr_data,

    output      logic                    csr_rsp_valid,
    output      logic [rop_pkg::xlen-1:0] csr_rsp_data,

    output      rop_pkg::rop_csrs_t      rop_csrs
);

    rop_pkg::rop_csrs_t       csrs_q;
    logic [rop_pkg::xlen-1:0] rd_value;
    logic                     do_write;
    logic                     do_read;

    assign do_write = csr_valid && csr_data.write;
    assign do_read  = csr_valid && !csr_data.write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csrs_q <= '0;
        end else if (do_write) begin
            case (csr_data.addr)
                rop_pkg::csr_zbuf_addr:      csrs_q.zbuf_addr      <= csr_data.wdata;
                rop_pkg::csr_zbuf_pitch:     csrs_q.zbuf_pitch     <= csr_data.wdata;
                rop_pkg::csr_cbuf_addr:      csrs_q.cbuf_addr      <= csr_data.wdata;
                rop_pkg::csr_cbuf_pitch:     csrs_q.cbuf_pitch     <= csr_data.wdata;
                rop_pkg::csr_cbuf_writemask: csrs_q.cbuf_writemask <= csr_data.wdata;
                rop_pkg::csr_depth_func:     csrs_q.depth_func     <= csr_data.wdata;
                rop_pkg::csr_stencil_ref:    csrs_q.stencil_ref    <= csr_data.wdata;
                rop_pkg::csr_blend_mode:     csrs_q.blend_mode     <= csr_data.wdata;
                default: ;
            endcase
        end
    end

    // read mux
    always_comb begin
        case (csr_data.addr)
            rop_pkg::csr_zbuf_addr:      rd_value = csrs_q.zbuf_addr;
            rop_pkg::csr_zbuf_pitch:     rd_value = csrs_q.zbuf_pitch;
            rop_pkg::csr_cbuf_addr:      rd_value = csrs_q.cbuf_addr;
            rop_pkg::csr_cbuf_pitch:     rd_value = csrs_q.cbuf_pitch;
            rop_pkg::csr_cbuf_writemask: rd_value = csrs_q.cbuf_writemask;
            rop_pkg::csr_depth_func:     rd_value = csrs_q.depth_func;
            rop_pkg::csr_stencil_ref:    rd_value = csrs_q.stencil_ref;
            rop_pkg::csr_blend_mode:     rd_value = csrs_q.blend_mode;
            default:                     rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_rsp_valid <= 1'b0;
        end else begin
            csr_rsp_valid <= do_read;
        end
    end

    always_ff @(posedge clk) begin
        if (do_read) begin
            csr_rsp_data <= rd_value;
        end
    end

    assign rop_csrs = csrs_q;

endmodule

`default_nettype wire

//--- rop_golden.txt
// kinds: 0 addr wdata = CSR write, 1 addr value = CSR read, 3 mask cycles = hold ready low
// 2 = execute: header pc rs1[0] rs1[1] rs2[0] rs2[1] rs3[0] rs3[1], then on the next line
// {pos_y,pos_x}[0] [1], {face,depth}[0] [1], color[0] [1]; f ends the file
1 0 00000000
1 1 00000000
1 2 00000000
1 3 00000000
1 4 00000000
1 5 00000000
1 6 00000000
1 7 00000000
2 10011302 80000100 00200021 fffffffe ff00ff00 11223344 12345678 abcdef01
  00200010 7fff7fff 10345678 00cdef01 ff00ff00 11223344
2 10022111 80000104 0abc2468 40000003 deadbeef 0f0f0f0f 00000001 ff800000
  0abc1234 40000001 00000001 10800000 deadbeef 0f0f0f0f
0 2 c0de0000
0 7 00000005
1 2 c0de0000
1 7 00000005
1 3 00000000
3 2 8
2 20033203 80000200 00000000 55555555 cafef00d 80000001 00ffffff 7f000000
  00000000 55552aaa 00ffffff 10000000 cafef00d 80000001
2 20040310 80000204 aaaaaaaa 00010001 01234567 76543210 89abcdef 00000100
  2aaa5555 00010000 00abcdef 10000100 01234567 76543210
2 20051001 80000208 02000201 80000000 33333333 44444444 00aa5500 ffffffff
  02000100 00000000 10aa5500 00ffffff 33333333 44444444
f

//--- rop_pkg.sv
// Shared definitions for the render-output agent.
// Holds the lane and word widths, the operand field positions, the
// CSR addresses and the packed structs of every channel.
// Other files refer to these by scoped names.

`default_nettype none

package rop_pkg;

    // core geometry
    localparam int num_lanes  = 2;
    localparam int thread_cnt = 4;
    localparam int warp_cnt   = 4;
    localparam int wid_bits   = $clog2(warp_cnt);
    localparam int pid_bits   = $clog2(thread_cnt / num_lanes);
    localparam int uuid_bits  = 16;
    localparam int xlen       = 32;
    localparam int rd_bits    = 5;

    // fragment field widths
    localparam int dim_bits   = 15;
    localparam int depth_bits = 24;

    // where each fragment field sits inside the lane operands
    localparam int face_bit   = 0;
    localparam int pos_x_lsb  = 1;
    localparam int pos_y_lsb  = 16;

    // configuration register addresses
    localparam int csr_addr_bits = 3;
    localparam logic [csr_addr_bits-1:0] csr_zbuf_addr      = 3'd0;
    localparam logic [csr_addr_bits-1:0] csr_zbuf_pitch     = 3'd1;
    localparam logic [csr_addr_bits-1:0] csr_cbuf_addr      = 3'd2;
    localparam logic [csr_addr_bits-1:0] csr_cbuf_pitch     = 3'd3;
    localparam logic [csr_addr_bits-1:0] csr_cbuf_writemask = 3'd4;
    localparam logic [csr_addr_bits-1:0] csr_depth_func     = 3'd5;
    localparam logic [csr_addr_bits-1:0] csr_stencil_ref    = 3'd6;
    localparam logic [csr_addr_bits-1:0] csr_blend_mode     = 3'd7;

    // request from the execute stage
    typedef struct packed {
        logic [uuid_bits-1:0]               uuid;
        logic [wid_bits-1:0]                wid;
        logic [num_lanes-1:0]               tmask;
        logic [xlen-1:0]                    pc;
        logic [pid_bits-1:0]                pid;
        logic                               sop;
        logic                               eop;
        logic [num_lanes-1:0][xlen-1:0]     rs1;
        logic [num_lanes-1:0][xlen-1:0]     rs2;
        logic [num_lanes-1:0][xlen-1:0]     rs3;
    } exec_req_t;

    // one fragment per lane towards the render-output unit
    typedef struct packed {
        logic [uuid_bits-1:0]               uuid;
        logic [num_lanes-1:0]               mask;
        logic [num_lanes-1:0][dim_bits-1:0] pos_x;
        logic [num_lanes-1:0][dim_bits-1:0] pos_y;
        logic [num_lanes-1:0][31:0]         color;
        logic [num_lanes-1:0][depth_bits-1:0] depth;
        logic [num_lanes-1:0]               face;
    } rop_req_t;

    // instruction retirement, no register writeback
    typedef struct packed {
        logic [uuid_bits-1:0]               uuid;
        logic [wid_bits-1:0]                wid;
        logic [num_lanes-1:0]               tmask;
        logic [xlen-1:0]                    pc;
        logic [pid_bits-1:0]                pid;
        logic                               sop;
        logic                               eop;
        logic [num_lanes-1:0][xlen-1:0]     data;
        logic [rd_bits-1:0]                 rd;
        logic                               wb;
    } commit_t;

    typedef struct packed {
        logic [xlen-1:0] zbuf_addr;
        logic [xlen-1:0] zbuf_pitch;
        logic [xlen-1:0] cbuf_addr;
        logic [xlen-1:0] cbuf_pitch;
        logic [xlen-1:0] cbuf_writemask;
        logic [xlen-1:0] depth_func;
        logic [xlen-1:0] stencil_ref;
        logic [xlen-1:0] blend_mode;
    } rop_csrs_t;

    typedef struct packed {
        logic                     write;
        logic [csr_addr_bits-1:0] addr;
        logic [xlen-1:0]          wdata;
    } csr_req_t;

endpackage

`default_nettype wire

//--- tb_rop_agent.sv
// Self-checking testbench for the render-output agent.
// Replays rop_golden.txt (CSR writes and reads, execute requests with the
// expected fragment fields, ready holds) with random output back-pressure.
// Every output transfer is checked against a scoreboard queue.

`timescale 1ns/1ps
`default_nettype none

module tb_rop_agent;

    logic                     clk = 1'b0;
    logic                     rst_n;
    logic                     exec_valid;
    logic                     exec_ready;
    rop_pkg::exec_req_t       exec_data;
    logic                     rop_valid;
    logic                     rop_ready;
    rop_pkg::rop_req_t        rop_data;
    logic                     commit_valid;
    logic                     commit_ready;
    rop_pkg::commit_t         commit_data;
    logic                     csr_valid;
    rop_pkg::csr_req_t        csr_data;
    logic                     csr_rsp_valid;
    logic [rop_pkg::xlen-1:0] csr_rsp_data;

    logic [31:0]       gold [256];
    rop_pkg::rop_req_t exp_rop;
    rop_pkg::commit_t  exp_commit;
    rop_pkg::rop_req_t rop_q [$];
    rop_pkg::commit_t  commit_q [$];
    int                cycles;
    int                limit;
    int                n_exec;
    int                hold_left;
    logic [1:0]        hold_mask;

    rop_agent dut0 (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    // output back-pressure, ready holds and the cycle limit
    initial begin
        void'($urandom(32'h87ad));
        forever begin
            @(negedge clk);
            cycles++;
            if (limit > 0 && cycles > limit) begin
                abort_run("timeout: the golden file did not finish within the cycle limit");
            end
            // by the last held cycle the stalled buffer must be full
            if (hold_left == 1) begin
                check_value("exec_ready", exec_ready, 1'b0);
            end
            rop_ready    = (hold_left > 0 && hold_mask[0]) ? 1'b0 : (($urandom % 10) < 7);
            commit_ready = (hold_left > 0 && hold_mask[1]) ? 1'b0 : (($urandom % 10) < 7);
            if (hold_left > 0) begin
                hold_left--;
            end
        end
    end

    // scoreboard
    always @(posedge clk) begin
        if (rst_n) begin
            if (exec_valid && exec_ready) begin
                rop_q.push_back(exp_rop);
                commit_q.push_back(exp_commit);
                n_exec++;
            end
            if (rop_valid && rop_ready) begin
                if (rop_q.size() == 0) begin
                    abort_run("rop output delivered a request that was never accepted");
                end else begin
                    check_value("rop_data", rop_data, rop_q.pop_front());
                end
            end
            if (commit_valid && commit_ready) begin
                if (commit_q.size() == 0) begin
                    abort_run("commit output delivered a record that was never accepted");
                end else begin
                    check_value("commit_data", commit_data, commit_q.pop_front());
                end
            end
        end
    end

    initial begin
        int p;
        int lines;
        int sent;
        rst_n        = 1'b0;
        exec_valid   = 1'b0;
        exec_data    = '0;
        rop_ready    = 1'b0;
        commit_ready = 1'b0;
        csr_valid    = 1'b0;
        csr_data     = '0;
        exp_rop      = '0;
        exp_commit   = '0;
        hold_mask    = '0;
        $readmemh("rop_golden.txt", gold);

        // an execute record spans two lines of the file
        p     = 0;
        lines = 0;
        while (p < $size(gold) && gold[p] inside {0, 1, 2, 3}) begin
            lines += (gold[p] == 2) ? 2 : 1;
            p     += (gold[p] == 2) ? 15 : 3;
        end
        limit = 20 * lines + 100;

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("rop_valid", rop_valid, 1'b0);
        check_value("commit_valid", commit_valid, 1'b0);
        check_value("csr_rsp_valid", csr_rsp_valid, 1'b0);

        p = 0;
        while (gold[p] !== 32'hf) begin
            case (gold[p])
                0, 1: begin
                    csr_valid      = 1'b1;
                    csr_data.write = (gold[p] == 0);
                    csr_data.addr  = gold[p+1][rop_pkg::csr_addr_bits-1:0];
                    csr_data.wdata = csr_data.write ? gold[p+2] : '0;
                    @(negedge clk);
                    csr_valid = 1'b0;
                    // only a read gets a response
                    check_value("csr_rsp_valid", csr_rsp_valid, gold[p] == 1);
                    if (gold[p] == 1) begin
                        check_value("csr_rsp_data", csr_rsp_data, gold[p+2]);
                    end
                    p += 3;
                end
                2: begin
                    // the header word packs uuid [31:16] wid [13:12] tmask [9:8] pid [4]
                    // sop [1] eop [0]
                    exec_data.uuid  = gold[p+1][31:16];
                    exec_data.wid   = gold[p+1][13:12];
                    exec_data.tmask = gold[p+1][9:8];
                    exec_data.pid   = gold[p+1][4];
                    exec_data.sop   = gold[p+1][1];
                    exec_data.eop   = gold[p+1][0];
                    exec_data.pc    = gold[p+2];
                    exp_rop         = '0;
                    exp_rop.uuid    = exec_data.uuid;
                    exp_rop.mask    = exec_data.tmask;
                    for (int i = 0; i < rop_pkg::num_lanes; i++) begin
                        exec_data.rs1[i] = gold[p+3+i];
                        exec_data.rs2[i] = gold[p+5+i];
                        exec_data.rs3[i] = gold[p+7+i];
                        exp_rop.pos_x[i] = gold[p+9+i][14:0];
                        exp_rop.pos_y[i] = gold[p+9+i][30:16];
                        exp_rop.face[i]  = gold[p+11+i][28];
                        exp_rop.depth[i] = gold[p+11+i][23:0];
                        exp_rop.color[i] = gold[p+13+i];
                    end
                    // bookkeeping passes through while data, rd and wb stay zero
                    exp_commit       = '0;
                    exp_commit.uuid  = exec_data.uuid;
                    exp_commit.wid   = exec_data.wid;
                    exp_commit.tmask = exec_data.tmask;
                    exp_commit.pc    = exec_data.pc;
                    exp_commit.pid   = exec_data.pid;
                    exp_commit.sop   = exec_data.sop;
                    exp_commit.eop   = exec_data.eop;
                    exec_valid       = 1'b1;
                    sent             = n_exec;
                    do begin
                        @(negedge clk);
                    end while (n_exec == sent);
                    exec_valid = 1'b0;
                    p += 15;
                end
                3: begin
                    @(posedge clk);
                    hold_mask = gold[p+1][1:0];
                    hold_left = gold[p+2];
                    @(negedge clk);
                    p += 3;
                end
                default: begin
                    abort_run("unknown record kind in rop_golden.txt");
                end
            endcase
        end

        // let both outputs drain
        while (rop_q.size() != 0 || commit_q.size() != 0) begin
            @(negedge clk);
        end
        // every accepted request has left, so nothing may still be pending
        check_value("rop_valid", rop_valid, 1'b0);
        check_value("commit_valid", commit_valid, 1'b0);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
